// File: ifetch_sub.f
src/fetch_pkg.sv
src/cache_pkg.sv
src/icache_if.sv
src/l1_icache.sv
src/fetch_unit.sv
src/ifetch_top.sv
verification/tb_clock_gen.sv
verification/ifetch_tb.sv

// File: src/cache_pkg.sv
package cache_pkg;

    // one cache line is eight 32-bit instructions
    localparam int line_w         = 256;
    localparam int words_per_line = 8;

    // byte-offset bits within a line
    localparam int offset_bits = 5;

    // bits that select a word within a line
    localparam int word_sel_bits = $clog2(words_per_line);

    // line count used unless the top level overrides it
    localparam int default_num_lines = 16;

    // refill FSM states
    // idle serves lookups, wait holds the memory request until done
    typedef enum logic {
        refill_idle,
        refill_wait
    } refill_state_t;

endpackage

// File: src/fetch_pkg.sv
package fetch_pkg;

    // address and instruction widths
    localparam int addr_w  = 32;
    localparam int instr_w = 32;

    // byte-offset bits inside one instruction word
    localparam int instr_byte_bits = 2;

    // sequential PC increment in bytes
    localparam logic [addr_w-1:0] pc_step = 32'd4;

    // value placed on ins_out when the cache has no instruction
    localparam logic [instr_w-1:0] bubble_instr = '0;

    // first PC after reset
    localparam logic [addr_w-1:0] default_reset_vector = 32'h0000_1000;

    // fetch stops for good once the PC reaches this address
    localparam logic [addr_w-1:0] default_halt_addr = 32'h0000_8000;

endpackage

// File: src/fetch_unit.sv
module fetch_unit #(
    parameter logic [fetch_pkg::addr_w-1:0] reset_vector = fetch_pkg::default_reset_vector,
    parameter logic [fetch_pkg::addr_w-1:0] halt_addr    = fetch_pkg::default_halt_addr
) (
    input  logic                          sys_clk,
    input  logic                          rst_n,
    input  logic                          do_jump,
    input  logic [fetch_pkg::addr_w-1:0]  jump_addr,
    input  logic                          stall,
    output logic                          global_stall,
    output logic [fetch_pkg::instr_w-1:0] ins_out,
    output logic [fetch_pkg::addr_w-1:0]  pc_out,
    output logic [fetch_pkg::addr_w-1:0]  next_pc_out,
    icache_if.fetch                       lookup
);

    logic [fetch_pkg::addr_w-1:0] pc;
    logic [fetch_pkg::addr_w-1:0] seq_pc;
    logic                         lookup_en;
    logic                         miss_stall_d;
    logic                         halted;
    logic                         hold_pc;

    assign seq_pc = pc + fetch_pkg::pc_step;
    assign halted = (pc == halt_addr);

    // first cycle out of reset has no lookup, so the PC waits for it
    assign hold_pc = stall || lookup.miss_stall || !lookup_en;

    assign lookup.rd_en = lookup_en;
    assign lookup.addr  = pc;

    // delayed miss lines up with the zero bubble on ins_out
    assign global_stall = stall || miss_stall_d;

    // lookup enable comes up on the first edge after reset
    always_ff @(posedge sys_clk or negedge rst_n) begin
        if (!rst_n) begin
            lookup_en <= 1'b0;
        end else begin
            lookup_en <= 1'b1;
        end
    end

    // PC update with halt above stall above jump
    always_ff @(posedge sys_clk or negedge rst_n) begin
        if (!rst_n) begin
            pc <= reset_vector;
        end else if (halted) begin
            pc <= pc;
        end else if (hold_pc) begin
            pc <= pc;
        end else if (do_jump) begin
            pc <= jump_addr;
        end else begin
            pc <= seq_pc;
        end
    end

    // outputs follow the current PC every cycle
    always_ff @(posedge sys_clk or negedge rst_n) begin
        if (!rst_n) begin
            pc_out       <= '0;
            next_pc_out  <= '0;
            ins_out      <= '0;
            miss_stall_d <= 1'b0;
        end else begin
            pc_out       <= pc;
            next_pc_out  <= seq_pc;
            miss_stall_d <= lookup.miss_stall;
            if (lookup.hit) begin
                ins_out <= lookup.data;
            end else begin
                ins_out <= fetch_pkg::bubble_instr;
            end
        end
    end

endmodule

// File: src/icache_if.sv
interface icache_if;

    // lookup enable, a level
    logic                          rd_en;
    // current PC
    logic [fetch_pkg::addr_w-1:0]  addr;
    // instruction word at addr
    logic [fetch_pkg::instr_w-1:0] data;
    logic                          hit;
    // high on a miss or while a refill is in flight
    logic                          miss_stall;

    modport fetch (
        output rd_en,
        output addr,
        input  data,
        input  hit,
        input  miss_stall
    );

    modport cache (
        input  rd_en,
        input  addr,
        output data,
        output hit,
        output miss_stall
    );

endinterface

// File: src/ifetch_top.sv
module ifetch_top #(
    parameter logic [fetch_pkg::addr_w-1:0] reset_vector = fetch_pkg::default_reset_vector,
    parameter logic [fetch_pkg::addr_w-1:0] halt_addr    = fetch_pkg::default_halt_addr,
    parameter int                           num_lines    = cache_pkg::default_num_lines
) (
    input  logic                          sys_clk,
    input  logic                          rst_n,

    // redirect from execute
    input  logic                          do_jump,
    input  logic [fetch_pkg::addr_w-1:0]  jump_addr,

    // external stall and cache invalidate
    input  logic                          stall,
    input  logic                          sync,

    // fetch outputs
    output logic                          global_stall,
    output logic [fetch_pkg::instr_w-1:0] ins_out,
    output logic [fetch_pkg::addr_w-1:0]  pc_out,
    output logic [fetch_pkg::addr_w-1:0]  next_pc_out,

    // line refill port to the memory side
    output logic                          mmu_read,
    output logic [fetch_pkg::addr_w-1:0]  mmu_addr,
    input  logic                          mmu_done,
    input  logic [cache_pkg::line_w-1:0]  mmu_read_data
);

    icache_if lookup_bus ();

    fetch_unit #(
        .reset_vector (reset_vector),
        .halt_addr    (halt_addr)
    ) u_fetch_unit (
        .sys_clk      (sys_clk),
        .rst_n        (rst_n),
        .do_jump      (do_jump),
        .jump_addr    (jump_addr),
        .stall        (stall),
        .global_stall (global_stall),
        .ins_out      (ins_out),
        .pc_out       (pc_out),
        .next_pc_out  (next_pc_out),
        .lookup       (lookup_bus.fetch)
    );

    l1_icache #(
        .num_lines     (num_lines)
    ) u_l1_icache (
        .sys_clk       (sys_clk),
        .rst_n         (rst_n),
        .lookup        (lookup_bus.cache),
        .sync          (sync),
        .mmu_read      (mmu_read),
        .mmu_addr      (mmu_addr),
        .mmu_done      (mmu_done),
        .mmu_read_data (mmu_read_data)
    );

endmodule

// File: src/l1_icache.sv
module l1_icache #(
    parameter int num_lines = cache_pkg::default_num_lines
) (
    input  logic                          sys_clk,
    input  logic                          rst_n,
    icache_if.cache                       lookup,
    input  logic                          sync,
    output logic                          mmu_read,
    output logic [fetch_pkg::addr_w-1:0]  mmu_addr,
    input  logic                          mmu_done,
    input  logic [cache_pkg::line_w-1:0]  mmu_read_data
);

    localparam int index_bits = $clog2(num_lines);
    localparam int tag_bits   = fetch_pkg::addr_w - index_bits - cache_pkg::offset_bits;

    // storage arrays
    logic [tag_bits-1:0]           tag_mem  [num_lines];
    logic [cache_pkg::line_w-1:0]  data_mem [num_lines];
    logic [num_lines-1:0]          valid;

    cache_pkg::refill_state_t      state;

    // line address captured when the miss is seen
    logic [fetch_pkg::addr_w-1:0]  miss_addr;

    // fields of the lookup address
    logic [index_bits-1:0]               lu_index;
    logic [tag_bits-1:0]                 lu_tag;
    logic [cache_pkg::word_sel_bits-1:0] lu_word;
    logic [fetch_pkg::addr_w-1:0]        lu_line_addr;

    // fields of the pending refill
    logic [index_bits-1:0]         miss_index;
    logic [tag_bits-1:0]           miss_tag;

    logic                          lookup_miss;
    logic                          refill_done;

    assign lu_index = lookup.addr[cache_pkg::offset_bits +: index_bits];
    assign lu_tag   = lookup.addr[fetch_pkg::addr_w-1 -: tag_bits];
    assign lu_word  = lookup.addr[fetch_pkg::instr_byte_bits +: cache_pkg::word_sel_bits];

    assign lu_line_addr = {lookup.addr[fetch_pkg::addr_w-1:cache_pkg::offset_bits],
                           {cache_pkg::offset_bits{1'b0}}};

    assign miss_index = miss_addr[cache_pkg::offset_bits +: index_bits];
    assign miss_tag   = miss_addr[fetch_pkg::addr_w-1 -: tag_bits];

    // combinational lookup
    assign lookup.hit  = valid[lu_index] && (tag_mem[lu_index] == lu_tag);
    assign lookup.data = data_mem[lu_index][lu_word*fetch_pkg::instr_w +: fetch_pkg::instr_w];

    assign lookup_miss = lookup.rd_en && !lookup.hit;

    assign lookup.miss_stall = lookup_miss || (state == cache_pkg::refill_wait);

    assign refill_done = (state == cache_pkg::refill_wait) && mmu_done;

    // request goes out on the first miss cycle, before the FSM has moved
    always_comb begin
        if (state == cache_pkg::refill_wait) begin
            mmu_read = 1'b1;
            mmu_addr = miss_addr;
        end else begin
            mmu_read = lookup_miss;
            mmu_addr = lu_line_addr;
        end
    end

    // refill FSM and valid bits
    always_ff @(posedge sys_clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= cache_pkg::refill_idle;
            valid <= '0;
        end else begin
            // sync wipes everything, the pending line is set again below
            if (sync) begin
                valid <= '0;
            end

            case (state)
                cache_pkg::refill_idle: begin
                    if (lookup_miss) begin
                        state <= cache_pkg::refill_wait;
                    end
                end
                cache_pkg::refill_wait: begin
                    if (mmu_done) begin
                        state             <= cache_pkg::refill_idle;
                        valid[miss_index] <= 1'b1;
                    end
                end
                default: begin
                    state <= cache_pkg::refill_idle;
                end
            endcase
        end
    end

    // miss address, tags and line data
    always_ff @(posedge sys_clk) begin
        if ((state == cache_pkg::refill_idle) && lookup_miss) begin
            miss_addr <= lu_line_addr;
        end

        if (refill_done) begin
            tag_mem[miss_index]  <= miss_tag;
            data_mem[miss_index] <= mmu_read_data;
        end
    end

endmodule

// File: verification/ifetch_tb.sv
module ifetch_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam logic [31:0] data_key   = 32'hC0DE_0000;
    localparam logic [31:0] halt_addr  = fetch_pkg::default_halt_addr;
    localparam int          wait_limit = 200;
    localparam int          num_lines  = cache_pkg::default_num_lines;
    localparam int          num_tests  = 7;

    typedef enum logic [2:0] {
        chk_seq, chk_refill, chk_jump, chk_stall, chk_sync, chk_halt
    } check_kind_t;

    typedef struct packed {
        logic [7:0]  cycles;
        logic        stall;
        logic        jump;
        logic [31:0] jaddr;
        logic        sync;
        check_kind_t kind;
    } entry_t;

    logic         sys_clk;
    logic         rst_n;
    logic         do_jump       = 1'b0;
    logic [31:0]  jump_addr     = '0;
    logic         stall         = 1'b0;
    logic         sync          = 1'b0;
    logic         mmu_done      = 1'b0;
    logic [255:0] mmu_read_data = '0;
    logic         global_stall;
    logic [31:0]  ins_out;
    logic [31:0]  pc_out;
    logic [31:0]  next_pc_out;
    logic         mmu_read;
    logic [31:0]  mmu_addr;

    entry_t entries [num_tests];

    // reference model and bookkeeping
    logic [31:0]          exp_pc = fetch_pkg::default_reset_vector;
    logic                 stall_d1 = 1'b0;
    logic                 stall_d2 = 1'b0;
    logic                 jump_d1 = 1'b0;
    logic [31:0]          jaddr_d1 = '0;
    logic [31:0]          pc_out_prev = '0;
    logic                 read_prev = 1'b0;
    logic [31:0]          addr_prev = '0;
    logic [31:0]          resident_line [num_lines];
    logic [num_lines-1:0] resident_valid = '0;
    logic [31:0]          req_lines [$];
    bit                   jump_taken = 1'b0;
    bit                   timed_out = 1'b0;
    int                   req_count = 0;
    int                   valid_count = 0;
    int                   check_count = 0;
    int                   error_count = 0;

    // memory responder state
    logic [31:0] lcg_state = 32'h941;
    logic [31:0] req_line = '0;
    logic        busy = 1'b0;
    int          delay_left = 0;

    tb_clock_gen #(.period_ns(100), .reset_cycles(3)) clk_gen (
        .sys_clk (sys_clk),
        .rst_n   (rst_n)
    );

    ifetch_top UUT (
        .sys_clk       (sys_clk),
        .rst_n         (rst_n),
        .do_jump       (do_jump),
        .jump_addr     (jump_addr),
        .stall         (stall),
        .sync          (sync),
        .global_stall  (global_stall),
        .ins_out       (ins_out),
        .pc_out        (pc_out),
        .next_pc_out   (next_pc_out),
        .mmu_read      (mmu_read),
        .mmu_addr      (mmu_addr),
        .mmu_done      (mmu_done),
        .mmu_read_data (mmu_read_data)
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    // each word holds its own byte address, scrambled by the key
    function automatic logic [255:0] build_line(input logic [31:0] line_addr);
        logic [255:0] line;
        int           k;
        for (k = 0; k < 8; k++) begin
            line[32*k +: 32] = (line_addr + 32'(4 * k)) ^ data_key;
        end
        return line;
    endfunction

    function automatic int line_index(input logic [31:0] addr);
        return int'(addr[cache_pkg::offset_bits +: $clog2(num_lines)]);
    endfunction

    function automatic string kind_name(input check_kind_t k);
        case (k)
            chk_seq:    return "sequential";
            chk_refill: return "refill";
            chk_jump:   return "jump";
            chk_stall:  return "stall";
            chk_sync:   return "sync";
            default:    return "halt";
        endcase
    endfunction

    task automatic check_that(input bit ok, input string what);
        check_count++;
        assert (ok) else begin
            $display("FAILED at %0t ns: %s", $time, what);
            error_count++;
        end
    endtask

    task automatic report_timeout(input string what);
        $display("timeout: %s did not finish within %0d cycles", what, wait_limit);
        timed_out = 1'b1;
    endtask

    // 1 to 6 cycles of latency per line
    always @(posedge sys_clk) begin
        if (rst_n !== 1'b1) begin
            mmu_done <= 1'b0;
            busy     <= 1'b0;
        end else begin
            mmu_done <= 1'b0;
            if (busy) begin
                if (delay_left == 0) begin
                    mmu_done      <= 1'b1;
                    mmu_read_data <= build_line(req_line);
                    busy          <= 1'b0;
                end else begin
                    delay_left <= delay_left - 1;
                end
            end else if (mmu_read && !mmu_done) begin
                lcg_state = lcg_next(lcg_state);
                busy       <= 1'b1;
                req_line   <= mmu_addr;
                delay_left <= int'((lcg_state >> 16) % 6);
            end
        end
    end

    // outputs seen here belong to the inputs of the previous cycle
    task automatic observe_cycle();
        logic [31:0] line;
        int          idx;
        if (sync) begin
            resident_valid = '0;
        end
        if (mmu_done) begin
            idx = line_index(mmu_addr);
            resident_line[idx]  = mmu_addr;
            resident_valid[idx] = 1'b1;
        end
        if (ins_out != '0) begin
            valid_count++;
            check_that(pc_out == exp_pc, $sformatf("pc_out %h, expected %h", pc_out, exp_pc));
            check_that(ins_out == (pc_out ^ data_key),
                       $sformatf("ins_out %h wrong for pc %h", ins_out, pc_out));
            // halt above stall above jump
            if (exp_pc != halt_addr && !stall_d1) begin
                if (jump_d1) begin
                    exp_pc     = jaddr_d1;
                    jump_taken = 1'b1;
                end else begin
                    exp_pc = exp_pc + 32'd4;
                end
            end
        end
        if (pc_out != '0) begin
            check_that(next_pc_out == pc_out + 32'd4,
                       $sformatf("next_pc_out %h for pc_out %h", next_pc_out, pc_out));
        end
        if (stall) begin
            check_that(global_stall, "global_stall low while stall is high");
        end
        // a refill in the previous cycle shows up as a bubble
        if (ins_out == '0 && read_prev) begin
            check_that(global_stall, "global_stall low during a miss bubble");
        end else if (ins_out != '0) begin
            check_that(global_stall == stall, "global_stall differs from stall after a hit");
        end
        if (stall_d2) begin
            check_that(pc_out == pc_out_prev,
                       $sformatf("pc_out moved from %h to %h under stall", pc_out_prev, pc_out));
        end
        if (mmu_read && !read_prev) begin
            line = {exp_pc[31:cache_pkg::offset_bits], {cache_pkg::offset_bits{1'b0}}};
            idx  = line_index(mmu_addr);
            req_count++;
            req_lines.push_back(mmu_addr);
            check_that(mmu_addr == line, $sformatf("mmu_addr %h, expected %h", mmu_addr, line));
            check_that(!(resident_valid[idx] && resident_line[idx] == mmu_addr),
                       $sformatf("request for line %h that is already filled", mmu_addr));
        end else if (mmu_read) begin
            check_that(mmu_addr == addr_prev, "mmu_addr changed during a request");
        end
        stall_d2    = stall_d1;
        stall_d1    = stall;
        jump_d1     = do_jump;
        jaddr_d1    = jump_addr;
        pc_out_prev = pc_out;
        read_prev   = mmu_read;
        addr_prev   = mmu_addr;
    endtask

    always @(negedge sys_clk) begin
        if (rst_n === 1'b1) begin
            observe_cycle();
        end
    end

    task automatic apply_entry(input int num, input entry_t e);
        int errors_at_start;
        int valid_at_start;
        int req_at_halt;
        int n;
        bit target_seen;
        bit target_requested;
        bit frozen;
        logic [31:0] first_pc;
        errors_at_start = error_count;
        valid_at_start  = valid_count;
        target_seen      = 1'b0;
        target_requested = 1'b0;
        frozen           = 1'b1;
        first_pc         = '0;
        req_lines.delete();
        @(posedge sys_clk);
        stall     <= e.stall;
        sync      <= e.sync;
        do_jump   <= e.jump;
        jump_addr <= e.jaddr;
        jump_taken = 1'b0;
        @(posedge sys_clk);
        sync <= 1'b0;
        // hold the redirect until the PC takes it
        if (e.jump) begin
            n = 0;
            while (!jump_taken && n < wait_limit) begin
                @(posedge sys_clk);
                n++;
            end
            do_jump <= 1'b0;
            if (!jump_taken) begin
                report_timeout($sformatf("redirect to %h", e.jaddr));
                return;
            end
        end
        if (e.kind == chk_halt) begin
            n = 0;
            while (!(pc_out == halt_addr && ins_out != '0) && n < wait_limit) begin
                @(negedge sys_clk);
                n++;
            end
            if (pc_out != halt_addr || ins_out == '0) begin
                report_timeout("run up to the halt address");
                return;
            end
            @(posedge sys_clk);
            do_jump     <= 1'b1;
            jump_addr   <= fetch_pkg::default_reset_vector;
            req_at_halt = req_count;
            for (n = 0; n < e.cycles; n++) begin
                @(negedge sys_clk);
                check_that(pc_out == halt_addr, $sformatf("pc_out left halt, now %h", pc_out));
            end
            @(posedge sys_clk);
            do_jump <= 1'b0;
            check_that(req_count == req_at_halt, "refill request raised after halt");
        end else begin
            for (n = 0; n < e.cycles; n++) begin
                @(negedge sys_clk);
                if (ins_out != '0 && pc_out == e.jaddr) begin
                    target_seen = 1'b1;
                end
                // pc_out already shows the held PC on the first cycle
                if (n == 0) begin
                    first_pc = pc_out;
                end
                if (pc_out != first_pc || !global_stall) begin
                    frozen = 1'b0;
                end
            end
            @(posedge sys_clk);
            foreach (req_lines[i]) begin
                if (req_lines[i] == e.jaddr) begin
                    target_requested = 1'b1;
                end
            end
            case (e.kind)
                chk_seq:    check_that(valid_count - valid_at_start >= 8, "too few instructions");
                chk_refill: check_that(req_lines.size() > 0, "no line refill requested");
                chk_jump:   check_that(target_seen, "nothing fetched at the jump target");
                chk_sync:   check_that(target_requested, "no refill of the line after sync");
                chk_stall:  check_that(frozen, "pc_out not held or global_stall low under stall");
            endcase
        end
        $display("test %0d %s: %0d errors", num, kind_name(e.kind), error_count - errors_at_start);
    endtask

    initial begin
        int n;
        int i;
        entries[0] = '{8'd60, 1'b0, 1'b0, 32'h0000_0000, 1'b0, chk_seq};
        entries[1] = '{8'd40, 1'b0, 1'b0, 32'h0000_0000, 1'b0, chk_refill};
        entries[2] = '{8'd40, 1'b0, 1'b1, 32'h0000_2040, 1'b0, chk_jump};
        entries[3] = '{8'd10, 1'b1, 1'b0, 32'h0000_0000, 1'b0, chk_stall};
        entries[4] = '{8'd20, 1'b0, 1'b0, 32'h0000_0000, 1'b0, chk_seq};
        // earlier line again, after invalidation
        entries[5] = '{8'd30, 1'b0, 1'b1, 32'h0000_1000, 1'b1, chk_sync};
        entries[6] = '{8'd20, 1'b0, 1'b1, 32'h0000_7FC0, 1'b0, chk_halt};
        n = 0;
        while (rst_n !== 1'b1 && n < wait_limit) begin
            @(posedge sys_clk);
            n++;
        end
        if (rst_n !== 1'b1) begin
            report_timeout("reset release");
        end
        for (i = 0; i < num_tests && !timed_out; i++) begin
            apply_entry(i, entries[i]);
        end
        $display("refills %0d, checks %0d, errors %0d", req_count, check_count, error_count);
        if (error_count == 0 && !timed_out) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

// File: verification/tb_clock_gen.sv
module tb_clock_gen #(
    parameter int period_ns    = 100,
    parameter int reset_cycles = 3
) (
    output logic sys_clk,
    output logic rst_n
);

    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        sys_clk = 1'b0;
        forever begin
            #(period_ns / 2) sys_clk = ~sys_clk;
        end
    end

    // release on a rising edge, after the reset cycles
    initial begin
        rst_n = 1'b0;
        repeat (reset_cycles) @(posedge sys_clk);
        rst_n <= 1'b1;
    end

endmodule
